/* sources.f */
+incdir+.
tdu_pkg.sv
tdu_csr_decode.sv
tdu_trigger.sv
tdu_hit_result.sv
tdu_top.sv
tb_tdu.sv

/* Makefile */
# Verilator build and run for the trigger debug unit testbench

SRCS = tdu_pkg.sv tdu_csr_decode.sv tdu_trigger.sv tdu_hit_result.sv tdu_top.sv \
       tb_tdu_model.svh tb_tdu.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_tdu: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_tdu -f sources.f -o Vtb_tdu

run: obj_dir/Vtb_tdu
	./obj_dir/Vtb_tdu > sim.log 2>&1; cat sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_tdu_model.svh */
//--------------------------------------------------------------------------
// TDU testbench reference model
// Shadow registers, expected outputs and the LFSR stimulus source
//--------------------------------------------------------------------------
`ifndef TB_TDU_MODEL_SVH
`define TB_TDU_MODEL_SVH

// Expected DUT outputs for one cycle
typedef struct packed {
    logic [DATA_W-1:0]   rdata;
    logic                resp;
    logic [TRIG_NUM-1:0] i_match;
    logic                i_x_req;
    logic [TRIG_NUM-1:0] d_match;
    logic                d_x_req;
    logic                dmode_req;
    logic                brk_en;
} tdu_exp_t;

logic [TSEL_W-1:0] sh_tsel;
trig_cfg_t         sh_cfg [TRIG_NUM];
logic [DATA_W-1:0] sh_tdata2 [TRIG_NUM];
logic [31:0]       lfsr_state = 32'h6f4e_f5f4;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v          = {v[30:0], fb};
    end
    return v;
endfunction

// Small address pool so that monitors hit tdata2 often
function automatic logic [DATA_W-1:0] pool_addr();
    return 32'h8000_0100 + (rand_bits(2) << 2);
endfunction

// tdata1 as software sees it, type 2 in the top nibble
function automatic logic [DATA_W-1:0] mcontrol_image(input trig_cfg_t c);
    return {4'd2, c.dmode, 6'd0, c.hit, 2'd0, 5'd0, c.action, c.chain,
            4'd0, c.m, 3'd0, c.execute, c.store, c.load};
endfunction

//--------------------------------------------------------------------------
// Reference function, reads the current inputs and the shadow
//--------------------------------------------------------------------------
function automatic tdu_exp_t ref_outputs();
    tdu_exp_t            e;
    logic [TRIG_NUM-1:0] ld_hit;
    logic                prev_ok;
    e      = '0;
    e.resp = csr_req.req ? OK : ER;
    if (csr_req.req) begin
        case (csr_req.addr)
            TSELECT: e.rdata = DATA_W'(sh_tsel);
            TDATA1:  e.rdata = mcontrol_image(sh_cfg[sh_tsel]);
            TDATA2:  e.rdata = sh_tdata2[sh_tsel];
            default: e.rdata = 32'h4;               // tinfo
        endcase
    end
    for (int i = 0; i < TRIG_NUM; i++) begin
        e.i_match[i] = !dsbl && sh_cfg[i].m && sh_cfg[i].execute && i_mon.vd &&
                       (i_mon.addr == sh_tdata2[i]);
        ld_hit[i]    = !dsbl && sh_cfg[i].m && d_mon.vd &&
                       ((sh_cfg[i].load && d_mon.load) || (sh_cfg[i].store && d_mon.store)) &&
                       (d_mon.addr == sh_tdata2[i]);
        e.dmode_req  = e.dmode_req | (sh_cfg[i].action & bp_retire[i]);
        e.brk_en     = e.brk_en | sh_cfg[i].m;
    end
    for (int i = 0; i < TRIG_NUM; i++) begin
        prev_ok = (i == 0) ? 1'b1 :
                  (!sh_cfg[i-1].chain || (ld_hit[i-1] && sh_tdata2[i-1] != sh_tdata2[i]));
        e.d_match[i] = ld_hit[i] && !sh_cfg[i].chain && prev_ok;
    end
    e.i_x_req = |e.i_match;
    e.d_x_req = |e.d_match;
    return e;
endfunction

`endif

/* tb_tdu.sv */
//--------------------------------------------------------------------------
// TDU testbench
// Random CSR traffic and monitor activity checked against a reference model
//--------------------------------------------------------------------------
`default_nettype none

module tb_tdu import tdu_pkg::*; ();

    logic                clk;
    logic                rst_n;
    logic                dsbl;
    csr_req_t            csr_req;
    i_mon_t              i_mon;
    d_mon_t              d_mon;
    logic [TRIG_NUM-1:0] bp_retire;
    logic [DATA_W-1:0]   csr_rdata;
    csr_resp_e           csr_resp;
    logic [TRIG_NUM-1:0] i_match;
    logic [TRIG_NUM-1:0] d_match;
    logic                i_x_req;
    logic                d_x_req;
    logic                dmode_req;
    logic                brk_en;
    int                  value_errs = 0;
    int                  timeout_errs = 0;

    `include "tb_tdu_model.svh"

    tdu_top dut0 (
        .clk(clk), .rst_n(rst_n), .dsbl(dsbl),
        .csr_req(csr_req), .csr_rdata(csr_rdata), .csr_resp(csr_resp),
        .i_mon(i_mon), .d_mon(d_mon), .bp_retire(bp_retire),
        .i_match(i_match), .i_x_req(i_x_req), .d_match(d_match), .d_x_req(d_x_req),
        .dmode_req(dmode_req), .brk_en(brk_en)
    );

    always #10 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("Fail %s expected %h got %h", name, exp, got);
        end
    endtask

    // Next shadow state from the inputs of the cycle just checked
    task automatic update_shadow(input tdu_exp_t e);
        logic                wr;
        logic [DATA_W-1:0]   d;
        logic                locked;
        logic [TRIG_NUM-1:0] hit_wr;
        wr     = 1'b0;
        d      = csr_req.wdata;
        hit_wr = '0;
        if (csr_req.req) begin
            case (csr_req.cmd)
                WRITE: wr = 1'b1;
                SET: begin
                    wr = |csr_req.wdata;
                    d  = e.rdata | csr_req.wdata;
                end
                CLEAR: begin
                    wr = |csr_req.wdata;
                    d  = e.rdata & ~csr_req.wdata;
                end
                default: wr = 1'b0;
            endcase
        end
        locked = sh_cfg[sh_tsel].dmode && !dsbl;
        if (wr && !locked && csr_req.addr == TDATA1) begin
            hit_wr[sh_tsel]        = 1'b1;
            sh_cfg[sh_tsel].dmode   = d[TDATA1_DMODE];
            sh_cfg[sh_tsel].m       = d[MCTL_M];
            sh_cfg[sh_tsel].execute = d[MCTL_EXECUTE];
            sh_cfg[sh_tsel].load    = d[MCTL_LOAD];
            sh_cfg[sh_tsel].store   = d[MCTL_STORE];
            sh_cfg[sh_tsel].hit     = d[MCTL_HIT];
            sh_cfg[sh_tsel].action  = d[MCTL_ACTION_HI:MCTL_ACTION_LO] == 6'd1;
            sh_cfg[sh_tsel].chain   = d[MCTL_CHAIN] && (sh_tsel != TSEL_W'(TRIG_NUM - 1));
        end
        if (wr && !locked && csr_req.addr == TDATA2) begin
            sh_tdata2[sh_tsel] = d;
        end
        for (int i = 0; i < TRIG_NUM; i++) begin
            if (bp_retire[i] && !hit_wr[i]) begin
                sh_cfg[i].hit = 1'b1;       // Retire loses to a CSR write
            end
        end
        if (wr && csr_req.addr == TSELECT && d < DATA_W'(TRIG_NUM)) begin
            sh_tsel = d[TSEL_W-1:0];
        end
    endtask

    //----------------------------------------------------------------------
    // Comparison against the reference on every falling edge
    //----------------------------------------------------------------------
    always @(negedge clk) begin
        tdu_exp_t e;
        if (!rst_n) begin
            sh_tsel = '0;
            for (int i = 0; i < TRIG_NUM; i++) begin
                sh_cfg[i]    = '0;
                sh_tdata2[i] = '0;
            end
        end else begin
            e = ref_outputs();
            check_val("csr_rdata", csr_rdata, e.rdata);
            check_val("csr_resp", 32'(csr_resp), 32'(e.resp));
            check_val("i_match", 32'(i_match), 32'(e.i_match));
            check_val("i_x_req", 32'(i_x_req), 32'(e.i_x_req));
            check_val("d_match", 32'(d_match), 32'(e.d_match));
            check_val("d_x_req", 32'(d_x_req), 32'(e.d_x_req));
            check_val("dmode_req", 32'(dmode_req), 32'(e.dmode_req));
            check_val("brk_en", 32'(brk_en), 32'(e.brk_en));
            update_shadow(e);
        end
    end

    //----------------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------------
    function automatic csr_req_t csr_op(input csr_cmd_e cmd, input tdu_csr_addr_e addr,
                                        input logic [DATA_W-1:0] wdata);
        return '{req: 1'b1, cmd: cmd, addr: addr, wdata: wdata};
    endfunction

    function automatic logic coin();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    task automatic drive_cycle(input csr_req_t req, input i_mon_t im, input d_mon_t dm,
                               input logic [TRIG_NUM-1:0] bp);
        @(posedge clk);
        csr_req   <= req;
        i_mon     <= im;
        d_mon     <= dm;
        bp_retire <= bp;
    endtask

    // One random cycle with t1_mask limiting the tdata1 write bits
    task automatic random_cycle(input logic [DATA_W-1:0] t1_mask);
        csr_req_t            req;
        i_mon_t              im;
        d_mon_t              dm;
        logic [TRIG_NUM-1:0] bp;
        req.req  = rand_bits(2) != 0;
        req.cmd  = csr_cmd_e'(2'(rand_bits(2)));
        req.addr = tdu_csr_addr_e'(2'(rand_bits(2)));
        case (req.addr)
            TSELECT: req.wdata = rand_bits(2);      // 3 is out of range
            TDATA1:  req.wdata = rand_bits(32) & t1_mask;
            TDATA2:  req.wdata = pool_addr();
            default: req.wdata = rand_bits(32);
        endcase
        if (rand_bits(3) == 0) begin
            req.wdata = '0;                         // Zero mask for set and clear
        end
        im = '{vd: coin(), req: 1'b1, addr: pool_addr()};
        dm = '{vd: coin(), load: coin(), store: coin(), addr: pool_addr()};
        bp = (rand_bits(3) == 0) ? TRIG_NUM'(rand_bits(TRIG_NUM)) : '0;
        drive_cycle(req, im, dm, bp);
        dsbl <= rand_bits(4) == 0;
    endtask

    // Read tdata1 until the hit bit shows up
    task automatic wait_hit_bit();
        int n;
        n = 0;
        drive_cycle(csr_op(READ, TDATA1, '0), '0, '0, '0);
        @(negedge clk);
        while (!csr_rdata[MCTL_HIT] && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!csr_rdata[MCTL_HIT]) begin
            timeout_errs++;
            $display("Timeout waiting for the hit bit of the selected trigger");
        end
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        rst_n     <= 1'b0;
        dsbl      <= 1'b0;
        csr_req   <= '0;
        i_mon     <= '0;
        d_mon     <= '0;
        bp_retire <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values
        drive_cycle('0, '0, '0, '0);
        drive_cycle(csr_op(READ, TDATA1, '0), '0, '0, '0);
        drive_cycle(csr_op(READ, TINFO, '0), '0, '0, '0);

        // CSR traffic with breakpoints and watchpoints but no debug-mode lock
        repeat (800) random_cycle(~(32'h1 << TDATA1_DMODE));
        dsbl <= 1'b0;

        // Retire on trigger 1 with action 1
        drive_cycle(csr_op(WRITE, TSELECT, 32'd1), '0, '0, '0);
        drive_cycle(csr_op(WRITE, TDATA1, 32'h0000_1044), '0, '0, '0);
        drive_cycle(csr_op(WRITE, TDATA2, 32'h8000_0104), '0, '0, '0);
        drive_cycle('0, '0, '0, 3'b010);
        wait_hit_bit();

        // Debug-mode lock and its release by dsbl
        drive_cycle(csr_op(WRITE, TDATA1, 32'h0800_1044), '0, '0, '0);
        drive_cycle(csr_op(WRITE, TDATA1, 32'h0), '0, '0, '0);
        drive_cycle(csr_op(WRITE, TDATA2, 32'h8000_0108), '0, '0, '0);
        drive_cycle(csr_op(READ, TDATA1, '0), '0, '0, '0);
        drive_cycle(csr_op(READ, TDATA2, '0), '0, '0, '0);
        drive_cycle(csr_op(WRITE, TDATA1, 32'h0), '0, '0, '0);
        dsbl <= 1'b1;
        drive_cycle(csr_op(READ, TDATA1, '0), '0, '0, '0);
        dsbl <= 1'b0;

        // Everything random including the locks
        repeat (400) random_cycle('1);
        drive_cycle('0, '0, '0, '0);
        repeat (2) @(posedge clk);

        $display("Errors: %0d value, %0d timeout", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tdu_top.sv */
//--------------------------------------------------------------------------
// Trigger debug unit top level
// CSR decode, three address-match triggers and hit result logic
//--------------------------------------------------------------------------
`default_nettype none

module tdu_top import tdu_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                dsbl,          // Global trigger disable
    input  csr_req_t                 csr_req,
    output logic [DATA_W-1:0]        csr_rdata,
    output csr_resp_e                csr_resp,
    input  i_mon_t                   i_mon,
    input  d_mon_t                   d_mon,
    input  wire logic [TRIG_NUM-1:0] bp_retire,
    output logic [TRIG_NUM-1:0]      i_match,
    output logic                     i_x_req,
    output logic [TRIG_NUM-1:0]      d_match,
    output logic                     d_x_req,
    output logic                     dmode_req,
    output logic                     brk_en
);

    csr_wr_t               csr_wr;
    logic [TRIG_NUM-1:0]   sel_tdata1;
    logic [TRIG_NUM-1:0]   sel_tdata2;
    trig_cfg_t             cfg [TRIG_NUM];
    logic [DATA_W-1:0]     tdata2 [TRIG_NUM];
    logic [TRIG_NUM-1:0]   exec_hit;
    logic [TRIG_NUM-1:0]   ldst_hit;

    tdu_csr_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_req    (csr_req),
        .cfg        (cfg),
        .tdata2     (tdata2),
        .csr_rdata  (csr_rdata),
        .csr_resp   (csr_resp),
        .sel_tdata1 (sel_tdata1),
        .sel_tdata2 (sel_tdata2),
        .csr_wr     (csr_wr)
    );

    for (genvar i = 0; i < TRIG_NUM; i++) begin : g_trig
        tdu_trigger #(
            .is_last (1'(i == TRIG_NUM - 1))
        ) u_trigger (
            .clk        (clk),
            .rst_n      (rst_n),
            .dsbl       (dsbl),
            .sel_tdata1 (sel_tdata1[i]),
            .sel_tdata2 (sel_tdata2[i]),
            .csr_wr     (csr_wr),
            .i_mon      (i_mon),
            .d_mon      (d_mon),
            .bp_retire  (bp_retire[i]),
            .cfg        (cfg[i]),
            .tdata2     (tdata2[i]),
            .exec_hit   (exec_hit[i]),
            .ldst_hit   (ldst_hit[i])
        );
    end

    tdu_hit_result u_result (
        .cfg        (cfg),
        .tdata2     (tdata2),
        .exec_hit   (exec_hit),
        .ldst_hit   (ldst_hit),
        .bp_retire  (bp_retire),
        .i_match    (i_match),
        .d_match    (d_match),
        .i_x_req    (i_x_req),
        .d_x_req    (d_x_req),
        .dmode_req  (dmode_req),
        .brk_en     (brk_en)
    );

endmodule

`default_nettype wire

/* tdu_hit_result.sv */
//--------------------------------------------------------------------------
// TDU hit result
// Watchpoint chaining, exception requests and debug-mode request
//--------------------------------------------------------------------------
`default_nettype none

module tdu_hit_result import tdu_pkg::*; (
    input  trig_cfg_t                cfg [TRIG_NUM],
    input  wire logic [DATA_W-1:0]   tdata2 [TRIG_NUM],
    input  wire logic [TRIG_NUM-1:0] exec_hit,
    input  wire logic [TRIG_NUM-1:0] ldst_hit,
    input  wire logic [TRIG_NUM-1:0] bp_retire,
    output logic [TRIG_NUM-1:0]      i_match,
    output logic [TRIG_NUM-1:0]      d_match,
    output logic                     i_x_req,
    output logic                     d_x_req,
    output logic                     dmode_req,
    output logic                     brk_en
);

    //----------------------------------------------------------------------
    // Watchpoint chaining
    //----------------------------------------------------------------------
    for (genvar i = 0; i < TRIG_NUM; i++) begin : g_chain
        if (i == 0) begin : g_first
            assign d_match[i] = ldst_hit[i] & ~cfg[i].chain;
        end else begin : g_next
            // Chained pair fires only if the lower one hit a different address
            assign d_match[i] = ldst_hit[i] & ~cfg[i].chain &
                                (~cfg[i-1].chain |
                                 (ldst_hit[i-1] & (tdata2[i-1] != tdata2[i])));
        end
    end

    assign i_match = exec_hit;
    assign i_x_req = |exec_hit;      // Breakpoint exception
    assign d_x_req = |d_match;       // Watchpoint exception

    // Debug-mode request and LSU breakpoint enable
    always_comb begin
        dmode_req = 1'b0;
        brk_en    = 1'b0;
        for (int i = 0; i < TRIG_NUM; i++) begin
            dmode_req = dmode_req | (cfg[i].action & bp_retire[i]);
            brk_en    = brk_en | cfg[i].m;
        end
    end

endmodule

`default_nettype wire

/* tdu_trigger.sv */
//--------------------------------------------------------------------------
// TDU address-match trigger
// Stores mcontrol fields and the compare address of one trigger, and
// detects execution and load/store hits against the monitors
//--------------------------------------------------------------------------
`default_nettype none

module tdu_trigger import tdu_pkg::*; #(
    parameter bit is_last = 1'b0       // Top trigger cannot chain
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                dsbl,
    input  wire logic                sel_tdata1,
    input  wire logic                sel_tdata2,
    input  csr_wr_t                  csr_wr,
    input  i_mon_t                   i_mon,
    input  d_mon_t                   d_mon,
    input  wire logic                bp_retire,
    output trig_cfg_t                cfg,
    output logic [DATA_W-1:0]        tdata2,
    output logic                     exec_hit,
    output logic                     ldst_hit
);

    logic wr_unlocked;
    logic wr_tdata1;
    logic wr_tdata2;
    logic ld_match;
    logic st_match;

    // A trigger owned by debug mode is locked unless the TDU is disabled
    assign wr_unlocked = ~cfg.dmode | dsbl;

    assign wr_tdata1 = sel_tdata1 & csr_wr.wr & wr_unlocked;
    assign wr_tdata2 = sel_tdata2 & csr_wr.wr & wr_unlocked;

    //----------------------------------------------------------------------
    // Configuration registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.dmode   <= 1'b0;
            cfg.m       <= 1'b0;
            cfg.execute <= 1'b0;
            cfg.load    <= 1'b0;
            cfg.store   <= 1'b0;
            cfg.action  <= 1'b0;
            cfg.chain   <= 1'b0;
        end else if (wr_tdata1) begin
            cfg.dmode   <= csr_wr.data[TDATA1_DMODE];
            cfg.m       <= csr_wr.data[MCTL_M];
            cfg.execute <= csr_wr.data[MCTL_EXECUTE];
            cfg.load    <= csr_wr.data[MCTL_LOAD];
            cfg.store   <= csr_wr.data[MCTL_STORE];
            // Only action 1 (debug mode) is kept, anything else is exception
            cfg.action  <= csr_wr.data[MCTL_ACTION_HI:MCTL_ACTION_LO] == 6'd1;
            cfg.chain   <= ~is_last & csr_wr.data[MCTL_CHAIN];
        end
    end

    // Sticky hit bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.hit <= 1'b0;
        end else if (wr_tdata1) begin
            cfg.hit <= csr_wr.data[MCTL_HIT];       // CSR write has priority
        end else if (bp_retire) begin
            cfg.hit <= 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // Compare address
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tdata2 <= '0;
        end else if (wr_tdata2) begin
            tdata2 <= csr_wr.data;
        end
    end

    //----------------------------------------------------------------------
    // Hit detection
    //----------------------------------------------------------------------

    // Execution breakpoint
    always_comb begin
        exec_hit = 1'b0;
        if (!dsbl && cfg.m && cfg.execute) begin
            exec_hit = i_mon.vd & (i_mon.addr == tdata2);
        end
    end

    // Access type qualifiers for the watchpoint
    assign ld_match = cfg.load & d_mon.load;
    assign st_match = cfg.store & d_mon.store;

    // Load/store watchpoint, equality match only
    always_comb begin
        ldst_hit = 1'b0;
        if (!dsbl && cfg.m && d_mon.vd && (ld_match || st_match)) begin
            ldst_hit = d_mon.addr == tdata2;
        end
    end

endmodule

`default_nettype wire

/* tdu_csr_decode.sv */
//--------------------------------------------------------------------------
// TDU CSR decode
// Holds tselect, builds read data and composes write/set/clear data
//--------------------------------------------------------------------------
`default_nettype none

module tdu_csr_decode import tdu_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  csr_req_t                 csr_req,
    input  trig_cfg_t                cfg [TRIG_NUM],
    input  wire logic [DATA_W-1:0]   tdata2 [TRIG_NUM],
    output logic [DATA_W-1:0]        csr_rdata,
    output csr_resp_e                csr_resp,
    output logic [TRIG_NUM-1:0]      sel_tdata1,
    output logic [TRIG_NUM-1:0]      sel_tdata2,
    output csr_wr_t                  csr_wr
);

    logic [TSEL_W-1:0] tselect;
    logic              sel_tselect;

    // mcontrol view of a stored trigger configuration
    function automatic logic [DATA_W-1:0] tdata1_word(input trig_cfg_t c);
        logic [DATA_W-1:0] w;
        w = '0;
        w[TDATA1_TYPE_HI:TDATA1_TYPE_LO] = MCTL_TYPE_VAL;
        w[TDATA1_DMODE]                  = c.dmode;
        w[MCTL_HIT]                      = c.hit;
        w[MCTL_ACTION_HI:MCTL_ACTION_LO] = 6'(c.action);
        w[MCTL_CHAIN]                    = c.chain;
        w[MCTL_M]                        = c.m;
        w[MCTL_EXECUTE]                  = c.execute;
        w[MCTL_STORE]                    = c.store;
        w[MCTL_LOAD]                     = c.load;
        return w;
    endfunction

    //----------------------------------------------------------------------
    // Address decode and read data
    //----------------------------------------------------------------------
    always_comb begin
        csr_rdata   = '0;
        sel_tselect = 1'b0;
        sel_tdata1  = '0;
        sel_tdata2  = '0;
        csr_resp    = csr_req.req ? OK : ER;

        if (csr_req.req) begin
            case (csr_req.addr)
                TSELECT: begin
                    sel_tselect = 1'b1;
                    csr_rdata   = DATA_W'(tselect);
                end
                TDATA1: begin
                    for (int i = 0; i < TRIG_NUM; i++) begin
                        if (tselect == TSEL_W'(i)) begin
                            sel_tdata1[i] = 1'b1;
                            csr_rdata     = tdata1_word(cfg[i]);
                        end
                    end
                end
                TDATA2: begin
                    for (int i = 0; i < TRIG_NUM; i++) begin
                        if (tselect == TSEL_W'(i)) begin
                            sel_tdata2[i] = 1'b1;
                            csr_rdata     = tdata2[i];
                        end
                    end
                end
                TINFO: begin
                    // Only mcontrol is supported
                    csr_rdata = DATA_W'(1) << MCTL_TYPE_VAL;
                end
                default: csr_rdata = '0;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Write data composition
    //----------------------------------------------------------------------
    always_comb begin
        csr_wr = '0;
        if (csr_req.req) begin
            case (csr_req.cmd)
                WRITE: begin
                    csr_wr.wr   = 1'b1;
                    csr_wr.data = csr_req.wdata;
                end
                SET: begin
                    csr_wr.wr   = |csr_req.wdata;            // No write on zero mask
                    csr_wr.data = csr_rdata | csr_req.wdata;
                end
                CLEAR: begin
                    csr_wr.wr   = |csr_req.wdata;
                    csr_wr.data = csr_rdata & ~csr_req.wdata;
                end
                READ:    csr_wr = '0;
                default: csr_wr = '0;
            endcase
        end
    end

    // Trigger select, out-of-range values dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tselect <= '0;
        end else if (sel_tselect && csr_wr.wr && (csr_wr.data < DATA_W'(TRIG_NUM))) begin
            tselect <= csr_wr.data[TSEL_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* tdu_pkg.sv */
//--------------------------------------------------------------------------
// Trigger debug unit package
// Widths, tdata1 field positions, CSR encodings and the port structs
//--------------------------------------------------------------------------
`default_nettype none

package tdu_pkg;

    // Sizes
    localparam int TRIG_NUM = 3;      // Address-match triggers
    localparam int TSEL_W   = 2;      // tselect width
    localparam int DATA_W   = 32;     // CSR data and address width

    //----------------------------------------------------------------------
    // tdata1 field positions
    //----------------------------------------------------------------------
    localparam int TDATA1_TYPE_HI  = 31;
    localparam int TDATA1_TYPE_LO  = 28;
    localparam int TDATA1_DMODE    = 27;

    localparam int MCTL_HIT        = 20;
    localparam int MCTL_ACTION_HI  = 17;
    localparam int MCTL_ACTION_LO  = 12;
    localparam int MCTL_CHAIN      = 11;
    localparam int MCTL_M          = 6;
    localparam int MCTL_EXECUTE    = 2;
    localparam int MCTL_STORE      = 1;
    localparam int MCTL_LOAD       = 0;

    // mcontrol type code, also the tinfo bit index
    localparam logic [3:0] MCTL_TYPE_VAL = 4'd2;

    //----------------------------------------------------------------------
    // CSR encodings
    //----------------------------------------------------------------------
    typedef enum logic [1:0] {
        TSELECT = 2'd0,
        TDATA1  = 2'd1,
        TDATA2  = 2'd2,
        TINFO   = 2'd3
    } tdu_csr_addr_e;

    typedef enum logic [1:0] {
        READ  = 2'd0,
        WRITE = 2'd1,
        SET   = 2'd2,
        CLEAR = 2'd3
    } csr_cmd_e;

    typedef enum logic {
        OK = 1'b0,
        ER = 1'b1
    } csr_resp_e;

    //----------------------------------------------------------------------
    // Port structs
    //----------------------------------------------------------------------
    typedef struct packed {
        logic                req;
        csr_cmd_e            cmd;
        tdu_csr_addr_e       addr;
        logic [DATA_W-1:0]   wdata;
    } csr_req_t;

    // Instruction monitor
    typedef struct packed {
        logic                vd;
        logic                req;      // Instruction accepted by the pipe
        logic [DATA_W-1:0]   addr;
    } i_mon_t;

    // Data monitor
    typedef struct packed {
        logic                vd;
        logic                load;
        logic                store;
        logic [DATA_W-1:0]   addr;
    } d_mon_t;

    // Stored mcontrol state of one trigger
    typedef struct packed {
        logic                dmode;
        logic                m;
        logic                execute;
        logic                load;
        logic                store;
        logic                action;   // 1 means enter debug mode
        logic                chain;
        logic                hit;
    } trig_cfg_t;

    // Composed write towards the triggers
    typedef struct packed {
        logic                wr;
        logic [DATA_W-1:0]   data;
    } csr_wr_t;

endpackage

`default_nettype wire
